//--- src/poly_pkg.sv
`default_nettype none

package poly_pkg;

	// ====================
	// sizes
	// ====================

	localparam int BUF_DEPTH  = 1024;             // sample buffer words
	localparam int BUF_AW     = 10;
	localparam int NUM_VECS   = 8;                // coefficient vectors
	localparam int VEC_AW     = 3;
	localparam int MAX_COEFFS = 16;               // per vector
	localparam int IDX_W      = 4;                // coeff index inside a vector
	localparam int S_AW       = VEC_AW + IDX_W;   // {vec, idx}, 7 bits
	localparam int LEN_W      = 5;                // N can be 0..16
	localparam int CNT_W      = 5;                // b
	localparam int DATA_W     = 16;               // x and c_i
	localparam int ACC_W      = 32;

	// ====================
	// host side records
	// ====================

	// one batch command, 18 bits
	typedef struct packed {
		logic [VEC_AW-1:0] vec;    // A
		logic [CNT_W-1:0]  count;  // b
		logic [BUF_AW-1:0] base;   // first sample address
	} evb_cmd_t;

	typedef struct packed {
		logic              en;
		logic [BUF_AW-1:0] addr;
		logic [DATA_W-1:0] data;
	} sample_wr_t;

	typedef struct packed {
		logic              en;
		logic [VEC_AW-1:0] vec;
		logic [IDX_W-1:0]  idx;
		logic [DATA_W-1:0] data;
	} coeff_wr_t;

	typedef struct packed {
		logic              en;
		logic [VEC_AW-1:0] vec;
		logic [LEN_W-1:0]  len;
	} len_wr_t;

	typedef struct packed {
		logic ovf;    // some step lost bits above 32
		logic empty;  // N was zero
	} evp_status_t;

	typedef struct packed {
		logic [ACC_W-1:0] value;
		evp_status_t      status;
		logic [CNT_W-1:0] idx;     // position in batch
		logic             last;
	} evp_result_t;

	// ====================
	// state machines
	// ====================

	typedef enum logic [1:0] {
		EVB_IDLE,
		EVB_START_EVP,
		EVB_WAIT_EVP,
		EVB_HOLD_RES
	} evb_state_t;

	typedef enum logic [2:0] {
		EVP_IDLE,
		EVP_RD_LEN,
		EVP_LOAD,
		EVP_STEP,
		EVP_DONE
	} evp_state_t;

endpackage

`default_nettype wire

//--- src/sample_buffer.sv
`default_nettype none
`timescale 1ns/100ps

// data RAM holding the x samples
module sample_buffer (
	input  logic                         clk,
	input  logic                         rst,
	input  poly_pkg::sample_wr_t         wr,       // host write
	input  logic                         rd_en,
	input  logic [poly_pkg::BUF_AW-1:0]  rd_addr,
	output logic [poly_pkg::DATA_W-1:0]  rd_data   // valid one cycle after rd_en
);

	logic [poly_pkg::DATA_W-1:0] mem [poly_pkg::BUF_DEPTH];

	// ====================
	// write port
	// ====================

	always_ff @(posedge clk)
	begin
		if (wr.en)
		begin
			mem[wr.addr] <= wr.data;  // lands on next edge
		end
	end

	// ====================
	// read port
	// ====================

	// registered read, holds last word when idle
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rd_data <= '0;
		end
		else if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- src/coeff_store.sv
`default_nettype none
`timescale 1ns/100ps

// S RAM (coefficients) and N RAM (vector lengths)
module coeff_store (
	input  logic                         clk,
	input  logic                         rst,
	input  poly_pkg::coeff_wr_t          coeff_wr,
	input  poly_pkg::len_wr_t            len_wr,
	input  logic                         len_rd_en,
	input  logic [poly_pkg::VEC_AW-1:0]  len_vec,
	output logic [poly_pkg::LEN_W-1:0]   len,
	input  logic                         s_rd_en,
	input  logic [poly_pkg::S_AW-1:0]    s_addr,
	output logic [poly_pkg::DATA_W-1:0]  s_data
);

	// S RAM is addressed {vec, idx}
	logic [poly_pkg::DATA_W-1:0] s_mem [poly_pkg::NUM_VECS * poly_pkg::MAX_COEFFS];
	logic [poly_pkg::LEN_W-1:0]  n_mem [poly_pkg::NUM_VECS];

	// ====================
	// S RAM
	// ====================

	always_ff @(posedge clk)
	begin
		if (coeff_wr.en)
		begin
			s_mem[{coeff_wr.vec, coeff_wr.idx}] <= coeff_wr.data;
		end
		if (s_rd_en)
		begin
			s_data <= s_mem[s_addr];  // one cycle latency
		end
	end

	// ====================
	// N RAM
	// ====================

	// cleared on reset, unloaded vectors read back as N = 0
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < poly_pkg::NUM_VECS; i++)
			begin
				n_mem[i] <= '0;
			end
			len <= '0;
		end
		else
		begin
			if (len_wr.en)
			begin
				n_mem[len_wr.vec] <= len_wr.len;
			end
			if (len_rd_en)
			begin
				len <= n_mem[len_vec];
			end
		end
	end

	// host must never load a vector longer than the S RAM row
	a_len_range: assert property (@(posedge clk) disable iff (!rst)
		len_wr.en |-> (len_wr.len <= poly_pkg::LEN_W'(poly_pkg::MAX_COEFFS)));

endmodule

`default_nettype wire

//--- src/horner_evp.sv
`default_nettype none
`timescale 1ns/100ps

// single polynomial evaluation, Horner's rule
// start -> done takes N+3 cycles (3 when N = 0)
module horner_evp (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         start,
	input  logic [poly_pkg::VEC_AW-1:0]  vec,
	input  logic [poly_pkg::BUF_AW-1:0]  x_addr,
	output logic                         x_rd_en,
	output logic [poly_pkg::BUF_AW-1:0]  x_rd_addr,
	input  logic [poly_pkg::DATA_W-1:0]  x_data,
	output logic                         len_rd_en,
	output logic [poly_pkg::VEC_AW-1:0]  len_vec,
	input  logic [poly_pkg::LEN_W-1:0]   len,
	output logic                         s_rd_en,
	output logic [poly_pkg::S_AW-1:0]    s_addr,
	input  logic [poly_pkg::DATA_W-1:0]  s_data,
	output logic                         done,
	output logic [poly_pkg::ACC_W-1:0]   value,
	output poly_pkg::evp_status_t        status
);

	poly_pkg::evp_state_t state;

	logic [poly_pkg::VEC_AW-1:0] vec_q;   // vector under evaluation
	logic [poly_pkg::DATA_W-1:0] x_q;
	logic [poly_pkg::IDX_W-1:0]  cidx;    // next coefficient to read
	logic [poly_pkg::LEN_W-1:0]  left;    // steps still to run
	logic [poly_pkg::ACC_W-1:0]  acc;
	logic                        ovf;     // sticky over the evaluation
	logic                        empty;
	logic [poly_pkg::ACC_W+poly_pkg::DATA_W:0] step_full;  // acc*x + c at full width

	// ====================
	// memory requests
	// ====================

	// N and x both fetched in the start cycle
	assign x_rd_en   = start && (state == poly_pkg::EVP_IDLE);
	assign x_rd_addr = x_addr;
	assign len_rd_en = x_rd_en;
	assign len_vec   = vec;

	// first read in LOAD, then one per STEP except the last
	assign s_rd_en = ((state == poly_pkg::EVP_LOAD) && (left != '0)) ||
		((state == poly_pkg::EVP_STEP) && (left > 1));
	assign s_addr  = {vec_q, cidx};

	// ====================
	// datapath
	// ====================

	assign step_full = acc * x_q + s_data;

	assign done   = (state == poly_pkg::EVP_DONE);
	assign value  = acc;
	assign status = '{ovf: ovf, empty: empty};

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= poly_pkg::EVP_IDLE;
			left  <= '0;
			acc   <= '0;
			ovf   <= 1'b0;
			empty <= 1'b0;
		end
		else
		begin
			case (state)
				poly_pkg::EVP_IDLE:
				begin
					if (start)
					begin
						state <= poly_pkg::EVP_RD_LEN;
					end
				end
				poly_pkg::EVP_RD_LEN:  // N and x on the RAM outputs now
				begin
					left  <= len;
					empty <= (len == '0);
					acc   <= '0;
					ovf   <= 1'b0;
					state <= poly_pkg::EVP_LOAD;
				end
				poly_pkg::EVP_LOAD:
				begin
					state <= (left == '0) ? poly_pkg::EVP_DONE : poly_pkg::EVP_STEP;
				end
				poly_pkg::EVP_STEP:
				begin
					acc  <= step_full[poly_pkg::ACC_W-1:0];  // wraps mod 2^32
					ovf  <= ovf | (|step_full[poly_pkg::ACC_W+poly_pkg::DATA_W:poly_pkg::ACC_W]);
					left <= left - 1'b1;
					if (left == 1)
					begin
						state <= poly_pkg::EVP_DONE;
					end
				end
				poly_pkg::EVP_DONE:
				begin
					state <= poly_pkg::EVP_IDLE;  // done is high for this one cycle
				end
				default:
				begin
					state <= poly_pkg::EVP_IDLE;
				end
			endcase
		end
	end

	// operand registers and coefficient index
	always_ff @(posedge clk)
	begin
		if (x_rd_en)
		begin
			vec_q <= vec;
		end
		if (state == poly_pkg::EVP_RD_LEN)
		begin
			x_q  <= x_data;
			cidx <= len[poly_pkg::IDX_W-1:0] - 1'b1;  // start at c_{N-1}
		end
		else if (s_rd_en)
		begin
			cidx <= cidx - 1'b1;
		end
	end

	// sequencer may only launch into an idle engine
	a_start_idle: assert property (@(posedge clk) disable iff (!rst)
		start |-> (state == poly_pkg::EVP_IDLE));

	// N read back must fit one S RAM row
	a_len_max: assert property (@(posedge clk) disable iff (!rst)
		(state == poly_pkg::EVP_RD_LEN) |-> (len <= poly_pkg::LEN_W'(poly_pkg::MAX_COEFFS)));

endmodule

`default_nettype wire

//--- src/evb_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

// batch sequencer running b evaluations over consecutive samples
module evb_sequencer (
	input  logic                         clk,
	input  logic                         rst,
	input  poly_pkg::evb_cmd_t           cmd,
	input  logic                         cmd_valid,
	output logic                         cmd_ready,
	output logic                         evp_start,
	output logic [poly_pkg::VEC_AW-1:0]  evp_vec,
	output logic [poly_pkg::BUF_AW-1:0]  evp_addr,
	input  logic                         evp_done,
	input  logic [poly_pkg::ACC_W-1:0]   evp_value,
	input  poly_pkg::evp_status_t        evp_status,
	output poly_pkg::evp_result_t        res,
	output logic                         res_valid,
	input  logic                         res_ready
);

	poly_pkg::evb_state_t state;

	logic [poly_pkg::VEC_AW-1:0] vec_q;   // A
	logic [poly_pkg::CNT_W-1:0]  cnt_q;   // b
	logic [poly_pkg::BUF_AW-1:0] base_q;
	logic [poly_pkg::CNT_W-1:0]  idx_q;   // evaluation in progress
	logic                        last;
	poly_pkg::evp_result_t       res_q;

	assign last      = (idx_q == cnt_q - 1'b1);
	assign cmd_ready = (state == poly_pkg::EVB_IDLE);
	assign evp_start = (state == poly_pkg::EVB_START_EVP);  // one cycle
	assign evp_vec   = vec_q;
	// wraps past the end of the sample buffer
	assign evp_addr  = base_q + {{(poly_pkg::BUF_AW - poly_pkg::CNT_W){1'b0}}, idx_q};
	assign res       = res_q;
	assign res_valid = (state == poly_pkg::EVB_HOLD_RES);

	// ====================
	// control
	// ====================

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= poly_pkg::EVB_IDLE;
			cnt_q <= '0;
			idx_q <= '0;
		end
		else
		begin
			case (state)
				poly_pkg::EVB_IDLE:
				begin
					if (cmd_valid)
					begin
						cnt_q <= cmd.count;
						idx_q <= '0;
						if (cmd.count != '0)  // b = 0 just stays idle
						begin
							state <= poly_pkg::EVB_START_EVP;
						end
					end
				end
				poly_pkg::EVB_START_EVP: state <= poly_pkg::EVB_WAIT_EVP;
				poly_pkg::EVB_WAIT_EVP:
				begin
					if (evp_done)
					begin
						state <= poly_pkg::EVB_HOLD_RES;
					end
				end
				poly_pkg::EVB_HOLD_RES:  // wait for the consumer
				begin
					if (res_ready)
					begin
						if (res_q.last)
						begin
							state <= poly_pkg::EVB_IDLE;
						end
						else
						begin
							idx_q <= idx_q + 1'b1;
							state <= poly_pkg::EVB_START_EVP;
						end
					end
				end
				default: state <= poly_pkg::EVB_IDLE;
			endcase
		end
	end

	// ====================
	// payload
	// ====================

	always_ff @(posedge clk)
	begin
		if (cmd_valid && cmd_ready)
		begin
			vec_q  <= cmd.vec;
			base_q <= cmd.base;
		end
		if ((state == poly_pkg::EVB_WAIT_EVP) && evp_done)
		begin
			res_q <= '{value: evp_value, status: evp_status, idx: idx_q, last: last};
		end
	end

	// a done outside WAIT_EVP would be lost
	a_done_expected: assert property (@(posedge clk) disable iff (!rst)
		evp_done |-> (state == poly_pkg::EVB_WAIT_EVP));

endmodule

`default_nettype wire

//--- src/poly_top.sv
`default_nettype none
`timescale 1ns/100ps

// polynomial evaluation block, top level
module poly_top (
	input  logic                   clk,
	input  logic                   rst,
	input  poly_pkg::sample_wr_t   sample_wr,
	input  poly_pkg::coeff_wr_t    coeff_wr,
	input  poly_pkg::len_wr_t      len_wr,
	input  poly_pkg::evb_cmd_t     cmd,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	output poly_pkg::evp_result_t  res,
	output logic                   res_valid,
	input  logic                   res_ready
);

	// engine <-> memories
	logic                        x_rd_en;
	logic [poly_pkg::BUF_AW-1:0] x_rd_addr;
	logic [poly_pkg::DATA_W-1:0] x_data;
	logic                        len_rd_en;
	logic [poly_pkg::VEC_AW-1:0] len_vec;
	logic [poly_pkg::LEN_W-1:0]  len;
	logic                        s_rd_en;
	logic [poly_pkg::S_AW-1:0]   s_addr;
	logic [poly_pkg::DATA_W-1:0] s_data;

	// sequencer <-> engine
	logic                        evp_start;
	logic [poly_pkg::VEC_AW-1:0] evp_vec;
	logic [poly_pkg::BUF_AW-1:0] evp_addr;
	logic                        evp_done;
	logic [poly_pkg::ACC_W-1:0]  evp_value;
	poly_pkg::evp_status_t       evp_status;

	sample_buffer u_samples (
		.clk(clk), .rst(rst), .wr(sample_wr),
		.rd_en(x_rd_en), .rd_addr(x_rd_addr), .rd_data(x_data)
	);

	coeff_store u_coeffs (
		.clk(clk), .rst(rst), .coeff_wr(coeff_wr), .len_wr(len_wr),
		.len_rd_en(len_rd_en), .len_vec(len_vec), .len(len),
		.s_rd_en(s_rd_en), .s_addr(s_addr), .s_data(s_data)
	);

	horner_evp u_evp (
		.clk(clk), .rst(rst), .start(evp_start), .vec(evp_vec), .x_addr(evp_addr),
		.x_rd_en(x_rd_en), .x_rd_addr(x_rd_addr), .x_data(x_data),
		.len_rd_en(len_rd_en), .len_vec(len_vec), .len(len),
		.s_rd_en(s_rd_en), .s_addr(s_addr), .s_data(s_data),
		.done(evp_done), .value(evp_value), .status(evp_status)
	);

	evb_sequencer u_evb (
		.clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.evp_start(evp_start), .evp_vec(evp_vec), .evp_addr(evp_addr),
		.evp_done(evp_done), .evp_value(evp_value), .evp_status(evp_status),
		.res(res), .res_valid(res_valid), .res_ready(res_ready)
	);

endmodule

`default_nettype wire

//--- sim/poly_checker.sv
`default_nettype none
`timescale 1ns/100ps

// scoreboard on the result port of poly_top
module poly_checker (
	input  logic                  clk,
	input  logic                  rst,
	input  poly_pkg::evp_result_t res,
	input  logic                  res_valid,
	input  logic                  res_ready,
	output int                    mismatches,
	output int                    other_errors,
	output int                    checked
);

	poly_pkg::evp_result_t exp_q [$];    // oldest first
	string                 name_q [$];   // test name per record
	poly_pkg::evp_result_t held;         // record seen on the last edge
	logic                  stalled = 1'b0;
	int                    n_mismatch = 0;
	int                    n_other = 0;
	int                    n_checked = 0;

	assign mismatches   = n_mismatch;
	assign other_errors = n_other;
	assign checked      = n_checked;

	// ====================
	// queue access
	// ====================

	task automatic push_expected(input poly_pkg::evp_result_t rec, input string name);
		exp_q.push_back(rec);
		name_q.push_back(name);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// leftovers at end of run, returns how many
	function automatic int report_missing();
		poly_pkg::evp_result_t rec;
		string                 name;
		int                    n;
		n = 0;
		while (exp_q.size() != 0)
		begin
			rec  = exp_q.pop_front();
			name = name_q.pop_front();
			$display("%s: expected result with idx %0d never arrived", name, rec.idx);
			n++;
		end
		return n;
	endfunction

	// ====================
	// compare
	// ====================

	task automatic check_field(input string name, input string field,
		input logic [31:0] want, input logic [31:0] got);
		if (want !== got)
		begin
			$display("Mismatch %s %s: expected %0h, actual %0h", name, field, want, got);
			n_mismatch++;
		end
	endtask

	task automatic score_record();
		poly_pkg::evp_result_t want;
		string                 name;
		if (exp_q.size() == 0)
		begin
			$display("result arrived with nothing expected (value %0h, idx %0d)",
				res.value, res.idx);
			n_other++;
		end
		else
		begin
			want = exp_q.pop_front();
			name = name_q.pop_front();
			n_checked++;
			check_field(name, "value", want.value, res.value);
			check_field(name, "ovf", 32'(want.status.ovf), 32'(res.status.ovf));
			check_field(name, "empty", 32'(want.status.empty), 32'(res.status.empty));
			check_field(name, "idx", 32'(want.idx), 32'(res.idx));
			check_field(name, "last", 32'(want.last), 32'(res.last));
		end
	endtask

	// sampled on the rising edge, same view as the DUT
	always @(posedge clk)
	begin
		if (!rst)
		begin
			stalled <= 1'b0;
		end
		else
		begin
			if (stalled && (!res_valid || (res !== held)))  // record must sit still
			begin
				$display("result record dropped or changed while res_ready was low");
				n_other++;
			end
			if (res_valid && res_ready)
			begin
				score_record();
			end
			stalled <= res_valid && !res_ready;
			held    <= res;
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_poly.sv
`default_nettype none
`timescale 1ns/100ps

module tb_poly;

	localparam int LOAD_CYCLES = poly_pkg::BUF_DEPTH + 2;  // all three RAMs load together
	localparam int MARGIN      = 400;

	logic                  clk = 1'b0;
	logic                  rst;
	poly_pkg::sample_wr_t  sample_wr;
	poly_pkg::coeff_wr_t   coeff_wr;
	poly_pkg::len_wr_t     len_wr;
	poly_pkg::evb_cmd_t    cmd;
	logic                  cmd_valid;
	logic                  cmd_ready;
	poly_pkg::evp_result_t res;
	logic                  res_valid;
	logic                  res_ready = 1'b0;

	// shadows of the loaded memories
	logic [poly_pkg::DATA_W-1:0] sample_sh [poly_pkg::BUF_DEPTH];
	logic [poly_pkg::DATA_W-1:0] coeff_sh  [poly_pkg::NUM_VECS][poly_pkg::MAX_COEFFS];
	logic [poly_pkg::LEN_W-1:0]  len_sh    [poly_pkg::NUM_VECS];

	// test list
	string t_name [$];
	int    t_vec  [$];
	int    t_cnt  [$];
	int    t_base [$];
	logic  t_bp   [$];

	logic [31:0] data_seed  = 32'd63;
	logic [31:0] ready_seed = 32'd63;
	logic        bp_on = 1'b0;          // random stalls on res_ready
	int          tb_mismatch = 0;
	int          tb_other = 0;
	int          cycle_count = 0;
	int          cycle_limit = 1000000;
	int          chk_mismatch;
	int          chk_other;
	int          chk_checked;

	always #4 clk = ~clk;  // 8 ns

	poly_top UUT (
		.clk(clk), .rst(rst), .sample_wr(sample_wr), .coeff_wr(coeff_wr), .len_wr(len_wr),
		.cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.res(res), .res_valid(res_valid), .res_ready(res_ready)
	);

	poly_checker chk (
		.clk(clk), .rst(rst), .res(res), .res_valid(res_valid), .res_ready(res_ready),
		.mismatches(chk_mismatch), .other_errors(chk_other), .checked(chk_checked)
	);

	// ====================
	// helpers
	// ====================

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		data_seed = lcg_step(data_seed);
		return data_seed;
	endfunction

	// Horner over the shadows in 64 bits so lost high bits stay visible
	function automatic poly_pkg::evp_result_t ref_eval(input int vec, input int addr,
		input int idx, input logic last);
		poly_pkg::evp_result_t r;
		logic [63:0]           full;
		logic [31:0]           acc;
		logic [15:0]           x;
		logic                  ovf;
		acc = '0;
		ovf = 1'b0;
		x   = sample_sh[addr];
		for (int i = int'(len_sh[vec]) - 1; i >= 0; i--)
		begin
			full = 64'(acc) * 64'(x) + 64'(coeff_sh[vec][i]);
			ovf  = ovf | (full[63:32] != '0);
			acc  = full[31:0];  // wraps
		end
		r.value        = acc;
		r.status.ovf   = ovf;
		r.status.empty = (len_sh[vec] == '0);
		r.idx          = poly_pkg::CNT_W'(idx);
		r.last         = last;
		return r;
	endfunction

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d other, %0d records checked",
			tb_mismatch + chk_mismatch, tb_other + chk_other, chk_checked);
	endtask

	task automatic add_test(input string name, input int vec, input int cnt,
		input int base, input logic bp);
		t_name.push_back(name);
		t_vec.push_back(vec);
		t_cnt.push_back(cnt);
		t_base.push_back(base);
		t_bp.push_back(bp);
	endtask

	task automatic build_test_list();
		logic [31:0] r;
		add_test("single_small_x2", 0, 1, 0, 1'b0);  // x^2 + 2x + 3 at x = 2
		add_test("single_small_x5", 0, 1, 1, 1'b0);
		add_test("single_len1", 1, 1, 2, 1'b0);
		add_test("overflow", 3, 3, 3, 1'b0);         // all 0xffff
		add_test("empty_vector", 2, 2, 6, 1'b0);
		add_test("zero_count", 0, 0, 0, 1'b0);
		for (int i = 0; i < 4; i++)
		begin
			r = next_rand();
			add_test($sformatf("batch_rand_%0d", i), int'(r[31:29]), 1 + int'(r[28:24]) % 20,
				int'(r[23:14]), i[0]);
		end
		add_test("batch_wrap", 5, 12, 1018, 1'b0);   // runs past address 1023
		add_test("backpressure", 6, 20, 100, 1'b1);
		add_test("wrap_backpressure", 7, 8, 1020, 1'b1);
	endtask

	// samples, coefficients and lengths share the same write cycles
	task automatic load_memories();
		logic [31:0] r;
		int          v;
		int          i;
		for (int a = 0; a < poly_pkg::BUF_DEPTH; a++)
		begin
			r = next_rand();
			if (a < 3)
				sample_sh[a] = 16'(2 + 3 * a);      // 2, 5, 8
			else if (a < 6)
				sample_sh[a] = 16'hffff;
			else
				sample_sh[a] = r[31:16];
			@(negedge clk);
			sample_wr = '{en: 1'b1, addr: poly_pkg::BUF_AW'(a), data: sample_sh[a]};
			coeff_wr  = '0;
			len_wr    = '0;
			if (a < poly_pkg::NUM_VECS * poly_pkg::MAX_COEFFS)
			begin
				v = a / poly_pkg::MAX_COEFFS;
				i = a % poly_pkg::MAX_COEFFS;
				r = next_rand();
				if (v == 0 && i < 3)
					coeff_sh[v][i] = 16'(3 - i);
				else if (v == 1)
					coeff_sh[v][i] = 16'd7;
				else if (v == 3)
					coeff_sh[v][i] = 16'hffff;
				else
					coeff_sh[v][i] = r[31:16];
				coeff_wr = '{en: 1'b1, vec: poly_pkg::VEC_AW'(v),
					idx: poly_pkg::IDX_W'(i), data: coeff_sh[v][i]};
			end
			if (a < poly_pkg::NUM_VECS)
			begin
				case (a)
					0: len_sh[a] = 5'd3;
					1: len_sh[a] = 5'd1;
					2: len_sh[a] = 5'd0;
					3: len_sh[a] = 5'd16;
					default: len_sh[a] = poly_pkg::LEN_W'(1 + r[27:24]);
				endcase
				len_wr = '{en: 1'b1, vec: poly_pkg::VEC_AW'(a), len: len_sh[a]};
			end
		end
		@(negedge clk);
		sample_wr = '0;
		coeff_wr  = '0;
		len_wr    = '0;
	endtask

	// issue one command and follow it until every record is taken
	task automatic run_batch(input int t);
		int   n;
		int   b;
		int   cycles;
		logic first_seen;
		logic ready_err;
		n = int'(len_sh[t_vec[t]]);
		b = t_cnt[t];
		for (int k = 0; k < b; k++)
		begin
			chk.push_expected(ref_eval(t_vec[t], (t_base[t] + k) % poly_pkg::BUF_DEPTH, k,
				k == b - 1), $sformatf("%s #%0d", t_name[t], k));
		end
		@(negedge clk);
		bp_on     <= t_bp[t];
		cmd       = '{vec: poly_pkg::VEC_AW'(t_vec[t]), count: poly_pkg::CNT_W'(b),
			base: poly_pkg::BUF_AW'(t_base[t])};
		cmd_valid = 1'b1;
		do
		begin
			@(posedge clk);
		end
		while (!cmd_ready);
		@(negedge clk);  // accepted on that edge
		cmd_valid = 1'b0;
		cmd       = '0;
		if (b == 0)
		begin
			@(posedge clk);
			if (!cmd_ready || res_valid)
			begin
				$display("%s: DUT did not stay idle after a zero count command", t_name[t]);
				tb_other++;
			end
		end
		else
		begin
			cycles     = 0;
			first_seen = 1'b0;
			ready_err  = 1'b0;
			do
			begin
				@(posedge clk);
				cycles++;
				if (cmd_ready && !ready_err)
				begin
					$display("%s: cmd_ready went high before the last record", t_name[t]);
					tb_other++;
					ready_err = 1'b1;
				end
				if (res_valid && !first_seen)
				begin
					first_seen = 1'b1;
					if (cycles != n + 5)
					begin
						$display("Mismatch %s first res_valid delay: expected %0d, actual %0d",
							t_name[t], n + 5, cycles);
						tb_mismatch++;
					end
				end
				@(negedge clk);
			end
			while (chk.pending() != 0);
			@(posedge clk);
			if (!cmd_ready)
			begin
				$display("%s: cmd_ready did not return high after the batch", t_name[t]);
				tb_other++;
			end
		end
	endtask

	// ====================
	// run
	// ====================

	always @(negedge clk)
	begin
		ready_seed = lcg_step(ready_seed);
		res_ready  = !bp_on || (ready_seed[31:30] != 2'b00);  // ready 3 of 4 when stalling
	end

	// records still queued here never came out of the DUT
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			tb_other += chk.report_missing();
			print_counts();
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		rst       = 1'b0;
		sample_wr = '0;
		coeff_wr  = '0;
		len_wr    = '0;
		cmd       = '0;
		cmd_valid = 1'b0;
		build_test_list();
		cycle_limit = LOAD_CYCLES + MARGIN + 10;
		foreach (t_cnt[t])
		begin
			cycle_limit += t_cnt[t] * (poly_pkg::MAX_COEFFS + 6);
		end
		repeat (10) @(negedge clk);
		rst = 1'b1;
		@(posedge clk);
		if (!cmd_ready || res_valid)
		begin
			$display("after reset cmd_ready should be high and res_valid low");
			tb_other++;
		end
		load_memories();
		foreach (t_name[t])
		begin
			run_batch(t);
		end
		repeat (4) @(negedge clk);
		print_counts();
		if (tb_mismatch + chk_mismatch + tb_other + chk_other == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
src/poly_pkg.sv
src/sample_buffer.sv
src/coeff_store.sv
src/horner_evp.sv
src/evb_sequencer.sv
src/poly_top.sv
sim/poly_checker.sv
sim/tb_poly.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the polynomial block testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal --top-module tb_poly -f src.f -o sim_poly
./obj_dir/sim_poly | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi
